// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ternary_cpu
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TEST OK

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
design/trit_pkg.sv
design/isa_pkg.sv
design/program_memory.sv
design/data_memory.sv
design/trit_alu.sv
design/operand_stack.sv
design/stack_controller.sv
design/ternary_cpu.sv
sim/clock_gen.sv
sim/ternary_cpu_assert.sv
sim/tb_ternary_cpu.sv

// ==== design/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic            clk,
    input  logic            we,
    input  logic [9:0]      addr,
    input  trit_pkg::word_t wdata,
    output trit_pkg::word_t rdata
);
    localparam int CELLS = 729;   // 3^6 cells

    trit_pkg::word_t mem [CELLS];
    logic            in_range;

    initial begin
        for (int i = 0; i < CELLS; i++) begin
            mem[i] = '0;
        end
    end

    assign in_range = (addr < 10'(CELLS));

    always_ff @(posedge clk) begin
        if (we && in_range) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = in_range ? mem[addr] : '0;   // Addresses 729 and up read as zero

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // Opcode numbers shared with the software VM
    typedef enum logic [7:0] {
        OP_PUSH       = 8'd0,
        OP_ADD        = 8'd1,
        OP_JMP        = 8'd3,
        OP_HALT       = 8'd5,
        OP_LOAD       = 8'd6,
        OP_STORE      = 8'd7,
        OP_SUB        = 8'd8,
        OP_DUP        = 8'd10,
        OP_DROP       = 8'd11,
        OP_SWAP       = 8'd12,
        OP_BRZ        = 8'd22,
        OP_NEG        = 8'd31,
        OP_CONSENSUS  = 8'd32,
        OP_ACCEPT_ANY = 8'd33
    } opcode_e;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEM
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_NEG,
        ALU_CONS,
        ALU_ANY
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_NONE,
        ST_PUSH,
        ST_POP,
        ST_POP2,
        ST_SET_TOP,
        ST_POP_SET,    // Pop, then overwrite the new top
        ST_SWAP
    } stack_op_e;

endpackage

// ==== design/operand_stack.sv ====
`timescale 1ns/1ps

module operand_stack #(
    parameter  int STACK_DEPTH = 16,
    localparam int DEPTH_W     = $clog2(STACK_DEPTH + 1)
) (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::stack_op_e op,
    input  trit_pkg::word_t    wdata,
    output trit_pkg::word_t    tos,
    output trit_pkg::word_t    nos,
    output logic [DEPTH_W-1:0] depth
);
    localparam int PTR_W = $clog2(STACK_DEPTH);

    trit_pkg::word_t  entries [STACK_DEPTH];
    logic [PTR_W-1:0] push_idx;
    logic [PTR_W-1:0] tos_idx;
    logic [PTR_W-1:0] nos_idx;

    // Slots are taken modulo the array size, so overflow wraps onto the bottom
    assign push_idx = PTR_W'(depth);
    assign tos_idx  = PTR_W'(depth - DEPTH_W'(1));
    assign nos_idx  = PTR_W'(depth - DEPTH_W'(2));

    assign tos = entries[tos_idx];
    assign nos = entries[nos_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth <= '0;
        end else begin
            case (op)
                isa_pkg::ST_PUSH:    depth <= depth + DEPTH_W'(1);
                isa_pkg::ST_POP:     depth <= depth - DEPTH_W'(1);
                isa_pkg::ST_POP_SET: depth <= depth - DEPTH_W'(1);
                isa_pkg::ST_POP2:    depth <= depth - DEPTH_W'(2);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (op)
            isa_pkg::ST_PUSH:    entries[push_idx] <= wdata;
            isa_pkg::ST_SET_TOP: entries[tos_idx] <= wdata;
            isa_pkg::ST_POP_SET: entries[nos_idx] <= wdata;   // nos becomes the top
            isa_pkg::ST_SWAP: begin
                entries[tos_idx] <= nos;
                entries[nos_idx] <= tos;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/program_memory.sv ====
`timescale 1ns/1ps

module program_memory (
    input  logic       clk,
    input  logic       we,
    input  logic [7:0] waddr,
    input  logic [7:0] wdata,
    input  logic [7:0] addr,
    output logic [7:0] data
);
    logic [7:0] mem [256];

    // Empty program reads as PUSH 0 until something is loaded
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign data = mem[addr];   // Follows pc without a clock

endmodule

// ==== design/stack_controller.sv ====
`timescale 1ns/1ps

module stack_controller #(
    parameter  int STACK_DEPTH = 16,
    localparam int DEPTH_W     = $clog2(STACK_DEPTH + 1)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         instr,
    input  trit_pkg::word_t    tos,
    input  trit_pkg::word_t    nos,
    input  logic [DEPTH_W-1:0] depth,
    input  trit_pkg::word_t    alu_result,
    input  trit_pkg::word_t    mem_rdata,
    output logic [7:0]         pc,
    output isa_pkg::stack_op_e stack_op,
    output trit_pkg::word_t    stack_wdata,
    output isa_pkg::alu_op_e   alu_op,
    output logic               mem_we,
    output logic [9:0]         mem_addr,
    output trit_pkg::word_t    mem_wdata,
    output trit_pkg::word_t    top_of_stack,
    output logic               halted,
    output logic [7:0]         pc_out
);
    isa_pkg::ctrl_state_e state;
    isa_pkg::opcode_e     opcode;
    logic [7:0]           operand;
    logic                 has_operand;

    // Opcodes followed by an operand byte
    assign has_operand = (opcode == isa_pkg::OP_PUSH) || (opcode == isa_pkg::OP_JMP) ||
                         (opcode == isa_pkg::OP_BRZ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= isa_pkg::FETCH;
            pc           <= 8'd0;
            pc_out       <= 8'd0;
            halted       <= 1'b0;
            mem_we       <= 1'b0;
            top_of_stack <= '0;
        end else if (!halted) begin
            mem_we <= 1'b0;   // Single-cycle write strobe
            pc_out <= pc;
            case (state)
                isa_pkg::FETCH: begin
                    pc    <= pc + 8'd1;
                    state <= isa_pkg::DECODE;
                end
                isa_pkg::DECODE: begin
                    if (has_operand) begin
                        pc <= pc + 8'd1;
                    end
                    state <= isa_pkg::EXECUTE;
                end
                isa_pkg::EXECUTE: begin
                    state <= isa_pkg::FETCH;
                    case (opcode)
                        isa_pkg::OP_STORE: mem_we <= 1'b1;
                        isa_pkg::OP_LOAD:  state <= isa_pkg::MEM;
                        isa_pkg::OP_JMP:   pc <= operand;
                        isa_pkg::OP_BRZ: begin
                            if (tos == '0) begin
                                pc <= operand;
                            end
                        end
                        isa_pkg::OP_HALT: begin
                            halted <= 1'b1;
                            if (depth != '0) begin
                                top_of_stack <= tos;   // Empty stack keeps the old value
                            end
                        end
                        default: ;   // Unknown bytes fall through as no-ops
                    endcase
                end
                default: state <= isa_pkg::FETCH;   // MEM, load data went to the stack
            endcase
        end
    end

    // Opcode, operand and memory request registers
    always_ff @(posedge clk) begin
        if (!halted) begin
            case (state)
                isa_pkg::FETCH:  opcode <= isa_pkg::opcode_e'(instr);
                isa_pkg::DECODE: operand <= instr;
                isa_pkg::EXECUTE: begin
                    mem_addr  <= (opcode == isa_pkg::OP_STORE) ? nos[9:0] : tos[9:0];
                    mem_wdata <= tos;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            isa_pkg::OP_SUB:        alu_op = isa_pkg::ALU_SUB;
            isa_pkg::OP_NEG:        alu_op = isa_pkg::ALU_NEG;
            isa_pkg::OP_CONSENSUS:  alu_op = isa_pkg::ALU_CONS;
            isa_pkg::OP_ACCEPT_ANY: alu_op = isa_pkg::ALU_ANY;
            default:                alu_op = isa_pkg::ALU_ADD;
        endcase
    end

    // Stack change, committed on the edge that leaves EXECUTE or MEM
    always_comb begin
        stack_op    = isa_pkg::ST_NONE;
        stack_wdata = alu_result;
        if (state == isa_pkg::EXECUTE) begin
            case (opcode)
                isa_pkg::OP_PUSH: begin
                    stack_op    = isa_pkg::ST_PUSH;
                    stack_wdata = trit_pkg::from_byte(operand);
                end
                isa_pkg::OP_DUP: begin
                    stack_op    = isa_pkg::ST_PUSH;
                    stack_wdata = tos;
                end
                isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                isa_pkg::OP_CONSENSUS, isa_pkg::OP_ACCEPT_ANY:
                    stack_op = isa_pkg::ST_POP_SET;
                isa_pkg::OP_NEG:                  stack_op = isa_pkg::ST_SET_TOP;
                isa_pkg::OP_DROP, isa_pkg::OP_BRZ: stack_op = isa_pkg::ST_POP;
                isa_pkg::OP_SWAP:                 stack_op = isa_pkg::ST_SWAP;
                isa_pkg::OP_STORE:                stack_op = isa_pkg::ST_POP2;
                default: ;
            endcase
        end else if (state == isa_pkg::MEM) begin
            stack_op    = isa_pkg::ST_SET_TOP;   // Loaded word replaces the address
            stack_wdata = mem_rdata;
        end
    end

endmodule

// ==== design/ternary_cpu.sv ====
`timescale 1ns/1ps

module ternary_cpu #(
    parameter int STACK_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            prog_we,
    input  logic [7:0]      prog_addr,
    input  logic [7:0]      prog_data,
    output trit_pkg::word_t top_of_stack,
    output logic            halted,
    output logic [7:0]      pc_out
);
    localparam int DEPTH_W = $clog2(STACK_DEPTH + 1);

    logic [7:0]         pc;
    logic [7:0]         instr;
    isa_pkg::stack_op_e stack_op;
    trit_pkg::word_t    stack_wdata;
    trit_pkg::word_t    tos;
    trit_pkg::word_t    nos;
    logic [DEPTH_W-1:0] depth;
    isa_pkg::alu_op_e   alu_op;
    trit_pkg::word_t    alu_result;
    logic               mem_we;
    logic [9:0]         mem_addr;
    trit_pkg::word_t    mem_wdata;
    trit_pkg::word_t    mem_rdata;

    program_memory prog_mem_i (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .addr  (pc),
        .data  (instr)
    );

    data_memory data_mem_i (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // Second operand on top of the stack, first one just below it
    trit_alu alu_i (
        .a      (nos),
        .b      (tos),
        .op     (alu_op),
        .result (alu_result)
    );

    operand_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) stack_i (
        .clk   (clk),
        .rst   (rst),
        .op    (stack_op),
        .wdata (stack_wdata),
        .tos   (tos),
        .nos   (nos),
        .depth (depth)
    );

    stack_controller #(
        .STACK_DEPTH (STACK_DEPTH)
    ) ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .tos          (tos),
        .nos          (nos),
        .depth        (depth),
        .alu_result   (alu_result),
        .mem_rdata    (mem_rdata),
        .pc           (pc),
        .stack_op     (stack_op),
        .stack_wdata  (stack_wdata),
        .alu_op       (alu_op),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .top_of_stack (top_of_stack),
        .halted       (halted),
        .pc_out       (pc_out)
    );

endmodule

// ==== design/trit_alu.sv ====
`timescale 1ns/1ps

module trit_alu (
    input  trit_pkg::word_t  a,
    input  trit_pkg::word_t  b,
    input  isa_pkg::alu_op_e op,
    output trit_pkg::word_t  result
);
    trit_pkg::word_t addend;
    trit_pkg::word_t sum;
    trit_pkg::word_t cons_word;
    trit_pkg::word_t any_word;

    // Trit code to -1, 0 or +1, the unused code counts as zero
    function automatic logic signed [1:0] trit_val(input trit_pkg::trit_t t);
        case (t)
            trit_pkg::TRIT_P: return 2'sb01;
            trit_pkg::TRIT_N: return 2'sb11;
            default:          return 2'sb00;
        endcase
    endfunction

    function automatic trit_pkg::trit_t trit_enc(input logic signed [1:0] v);
        case (v)
            2'sb01:  return trit_pkg::TRIT_P;
            2'sb11:  return trit_pkg::TRIT_N;
            default: return trit_pkg::TRIT_Z;
        endcase
    endfunction

    assign addend = (op == isa_pkg::ALU_SUB) ? trit_pkg::trit_negate(b) : b;

    // Ripple of balanced full adders, carry in and out is -1, 0 or +1
    always_comb begin : ripple
        logic signed [2:0] carry;
        logic signed [2:0] s;
        carry = 3'sd0;
        sum   = '0;
        for (int i = 0; i < trit_pkg::WORD_TRITS; i++) begin
            s = trit_val(a[2*i +: 2]) + trit_val(addend[2*i +: 2]) + carry;
            if (s > 3'sd1) begin
                sum[2*i +: 2] = trit_enc(2'(s - 3'sd3));
                carry = 3'sd1;
            end else if (s < -3'sd1) begin
                sum[2*i +: 2] = trit_enc(2'(s + 3'sd3));
                carry = -3'sd1;
            end else begin
                sum[2*i +: 2] = trit_enc(2'(s));
                carry = 3'sd0;
            end
        end
        // Carry out of trit 8 is dropped
    end

    // Consensus is the per-trit minimum, accept-any the maximum
    for (genvar i = 0; i < trit_pkg::WORD_TRITS; i++) begin : g_logic
        logic signed [1:0] va;
        logic signed [1:0] vb;

        assign va = trit_val(a[2*i +: 2]);
        assign vb = trit_val(b[2*i +: 2]);

        assign cons_word[2*i +: 2] = trit_enc((va < vb) ? va : vb);
        assign any_word[2*i +: 2]  = trit_enc((va > vb) ? va : vb);
    end

    always_comb begin
        case (op)
            isa_pkg::ALU_NEG:  result = trit_pkg::trit_negate(b);
            isa_pkg::ALU_CONS: result = cons_word;
            isa_pkg::ALU_ANY:  result = any_word;
            default:           result = sum;   // ADD and SUB
        endcase
    end

endmodule

// ==== design/trit_pkg.sv ====
package trit_pkg;

    // One balanced trit in two bits, the code 2'b11 is never produced
    typedef logic [1:0] trit_t;

    localparam trit_t TRIT_Z = 2'b00;
    localparam trit_t TRIT_P = 2'b01;
    localparam trit_t TRIT_N = 2'b10;

    localparam int WORD_TRITS = 9;

    typedef logic [2*WORD_TRITS-1:0] word_t;   // Trit 0 in bits [1:0]

    localparam word_t MINUS_ONE_WORD = {WORD_TRITS{TRIT_N}};   // Also the mask of high bits

    // Swap the bits of every pair, so P and N trade places and Z stays
    function automatic word_t trit_negate(input word_t w);
        return ((w << 1) & MINUS_ONE_WORD) | ((w & MINUS_ONE_WORD) >> 1);
    endfunction

    // Signed byte to balanced ternary, magnitude first and sign applied last
    function automatic word_t from_byte(input logic signed [7:0] val);
        int    mag;
        word_t w;
        mag = (val < 0) ? -int'(val) : int'(val);
        w   = '0;
        for (int i = 0; i < WORD_TRITS; i++) begin
            case (mag % 3)
                1: begin
                    w[2*i +: 2] = TRIT_P;
                    mag = mag / 3;
                end
                2: begin
                    w[2*i +: 2] = TRIT_N;   // Digit 2 becomes -1 with a carry up
                    mag = mag / 3 + 1;
                end
                default: mag = mag / 3;
            endcase
        end
        return (val < 0) ? trit_negate(w) : w;
    endfunction

endpackage

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 10
) (
    input  logic rst_req,
    output logic clk,
    output logic rst
);
    int por_count = 0;

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    always @(posedge clk) begin
        if (por_count < RST_CYCLES) begin
            por_count <= por_count + 1;
        end
    end

    // Power-on reset, stretched by the testbench while it loads a program
    assign rst = (por_count < RST_CYCLES) || rst_req;

endmodule

// ==== sim/tb_ternary_cpu.sv ====
`timescale 1ns/1ps

module tb_ternary_cpu;

    localparam int STACK_DEPTH  = 16;
    localparam int FIXED_TESTS  = 14;
    localparam int RANDOM_TESTS = 20;
    localparam int WATCHDOG_NS  = (FIXED_TESTS + RANDOM_TESTS) * 256 * 4 * 4 * 2;

    // Opcode numbers of the instruction set
    localparam int OP_PUSH  = 0;
    localparam int OP_ADD   = 1;
    localparam int OP_JMP   = 3;
    localparam int OP_HALT  = 5;
    localparam int OP_LOAD  = 6;
    localparam int OP_STORE = 7;
    localparam int OP_SUB   = 8;
    localparam int OP_DUP   = 10;
    localparam int OP_DROP  = 11;
    localparam int OP_SWAP  = 12;
    localparam int OP_BRZ   = 22;
    localparam int OP_NEG   = 31;
    localparam int OP_CONS  = 32;
    localparam int OP_ANY   = 33;

    logic            clk;
    logic            rst;
    logic            rst_req;
    logic            prog_we;
    logic [7:0]      prog_addr;
    logic [7:0]      prog_data;
    trit_pkg::word_t top_of_stack;
    logic            halted;
    logic [7:0]      pc_out;

    logic [7:0]      prog [256];       // Mirror of the program memory contents
    int              prog_len;
    int              model_mem [729];  // Mirror of the data memory that persists across tests
    trit_pkg::word_t expected;
    logic [7:0]      expected_pc;
    string           test_name;
    int              tests_started = 0;
    int              tests_checked = 0;
    int              n_pass = 0;
    int              n_fail = 0;

    clock_gen #(
        .PERIOD_NS  (4),
        .RST_CYCLES (10)
    ) clk_gen_i (
        .rst_req (rst_req),
        .clk     (clk),
        .rst     (rst)
    );

    ternary_cpu #(
        .STACK_DEPTH (STACK_DEPTH)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .top_of_stack (top_of_stack),
        .halted       (halted),
        .pc_out       (pc_out)
    );

    bind ternary_cpu ternary_cpu_assert #(
        .STACK_DEPTH (STACK_DEPTH)
    ) assert_i (
        .clk      (clk),
        .rst      (rst),
        .stack_op (stack_op),
        .depth    (depth),
        .halted   (halted)
    );

    // Balanced digit i of an integer counted from the low end
    function automatic int trit_at(input int v, input int i);
        int rest;
        int r;
        int d;
        rest = v;
        d    = 0;
        for (int k = 0; k <= i; k++) begin
            r    = ((rest % 3) + 3) % 3;
            d    = (r == 2) ? -1 : r;
            rest = (rest - d) / 3;
        end
        return d;
    endfunction

    // Keeps the low nine trits and drops the carry above them
    function automatic int wrap9(input int v);
        int res;
        int p;
        res = 0;
        p   = 1;
        for (int i = 0; i < 9; i++) begin
            res = res + trit_at(v, i) * p;
            p   = p * 3;
        end
        return res;
    endfunction

    function automatic int trit_logic(input int a, input int b, input bit take_max);
        int x;
        int y;
        int res;
        int p;
        res = 0;
        p   = 1;
        for (int i = 0; i < 9; i++) begin
            x = trit_at(a, i);
            y = trit_at(b, i);
            if (take_max) begin
                res = res + ((x > y) ? x : y) * p;
            end else begin
                res = res + ((x < y) ? x : y) * p;
            end
            p = p * 3;
        end
        return res;
    endfunction

    function automatic trit_pkg::word_t encode(input int v);
        trit_pkg::word_t w;
        int t;
        w = '0;
        for (int i = 0; i < 9; i++) begin
            t = trit_at(v, i);
            if (t == 1) begin
                w[2*i +: 2] = 2'b01;
            end else if (t == -1) begin
                w[2*i +: 2] = 2'b10;
            end
        end
        return w;
    endfunction

    // Interpreter of the byte program on integer stack words
    function automatic trit_pkg::word_t run_model(output logic [7:0] final_pc);
        int              stk [32];
        logic [4:0]      sp;
        logic [7:0]      pc;
        logic [7:0]      next_pc;
        logic [7:0]      arg;
        int              op;
        int              a;
        int              b;
        int              steps;
        bit              done;
        trit_pkg::word_t aw;
        trit_pkg::word_t res;
        sp       = '0;
        pc       = '0;
        steps    = 0;
        done     = 1'b0;
        res      = '0;
        final_pc = '0;
        while (!done && steps < 4096) begin
            op      = int'(prog[pc]);
            arg     = prog[pc + 8'd1];
            a       = stk[sp - 5'd2];
            b       = stk[sp - 5'd1];
            next_pc = pc + 8'd1;
            case (op)
                OP_PUSH: begin
                    stk[sp] = int'($signed(arg));
                    sp      = sp + 5'd1;
                    next_pc = pc + 8'd2;
                end
                OP_ADD, OP_SUB, OP_CONS, OP_ANY: begin
                    sp = sp - 5'd1;
                    if (op == OP_ADD) begin
                        stk[sp - 5'd1] = wrap9(a + b);
                    end else if (op == OP_SUB) begin
                        stk[sp - 5'd1] = wrap9(a - b);
                    end else begin
                        stk[sp - 5'd1] = trit_logic(a, b, op == OP_ANY);
                    end
                end
                OP_NEG: stk[sp - 5'd1] = -b;
                OP_DUP: begin
                    stk[sp] = b;
                    sp      = sp + 5'd1;
                end
                OP_DROP: sp = sp - 5'd1;
                OP_SWAP: begin
                    stk[sp - 5'd1] = a;
                    stk[sp - 5'd2] = b;
                end
                OP_LOAD: begin
                    aw = encode(b);  // Address is the low ten bits of the encoded word
                    stk[sp - 5'd1] = (aw[9:0] < 10'd729) ? model_mem[aw[9:0]] : 0;
                end
                OP_STORE: begin
                    aw = encode(a);
                    if (aw[9:0] < 10'd729) begin
                        model_mem[aw[9:0]] = b;
                    end
                    sp = sp - 5'd2;
                end
                OP_JMP: next_pc = arg;
                OP_BRZ: begin
                    sp      = sp - 5'd1;
                    next_pc = (b == 0) ? arg : pc + 8'd2;
                end
                OP_HALT: begin
                    done     = 1'b1;
                    res      = (sp != 5'd0) ? encode(b) : '0;
                    final_pc = pc + 8'd1;   // pc stops just past the HALT byte
                end
                default: ;
            endcase
            pc    = next_pc;
            steps = steps + 1;
        end
        return res;
    endfunction

    task automatic emit(input int b);
        prog[8'(prog_len)] = 8'(b);
        prog_len = prog_len + 1;
    endtask

    task automatic emit_push(input int v);
        emit(OP_PUSH);
        emit(v);
    endtask

    function automatic int random_byte();
        return int'($urandom_range(255)) - 128;
    endfunction

    // Straight-line program whose depth stays within 1..15
    task automatic build_random_program();
        int d;
        int n_ops;
        int pick;
        prog_len = 0;
        emit_push(random_byte());
        d     = 1;
        n_ops = 8 + int'($urandom_range(40));
        for (int k = 0; k < n_ops; k++) begin
            pick = int'($urandom_range(7));
            if (pick <= 2 && d >= 15) begin
                emit(OP_ADD);
                d = d - 1;
            end else if (pick <= 1) begin
                emit_push(random_byte());
                d = d + 1;
            end else if (pick == 2) begin
                emit(OP_DUP);
                d = d + 1;
            end else if (pick == 3 || d < 2) begin
                emit(OP_NEG);
            end else begin
                case (pick)
                    4:       emit(($urandom_range(1) == 0) ? OP_ADD : OP_SUB);
                    5:       emit(($urandom_range(1) == 0) ? OP_CONS : OP_ANY);
                    6:       emit(OP_SWAP);
                    default: emit(OP_DROP);
                endcase
                if (pick != 6) begin
                    d = d - 1;
                end
            end
        end
        emit(OP_HALT);
    endtask

    // Load under reset and let the program run to its halt
    task automatic run_test(input string name);
        @(posedge clk);
        rst_req <= 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= prog[8'(i)];
        end
        @(posedge clk);
        prog_we       <= 1'b0;
        expected      = run_model(expected_pc);
        test_name     = name;
        tests_started = tests_started + 1;
        @(posedge clk);
        rst_req <= 1'b0;
        while (tests_checked != tests_started) begin
            @(negedge clk);
        end
    endtask

    // Compare once per test at the first falling edge that sees halted
    always @(negedge clk) begin : compare
        bit test_ok;
        if (!rst && halted && tests_checked != tests_started) begin
            test_ok = 1'b1;
            if (top_of_stack !== expected) begin
                $display("Mismatch %s top_of_stack: expected %h, actual %h", test_name,
                         expected, top_of_stack);
                test_ok = 1'b0;
            end
            if (pc_out !== expected_pc) begin
                $display("Mismatch %s pc_out: expected %h, actual %h", test_name,
                         expected_pc, pc_out);
                test_ok = 1'b0;
            end
            if (test_ok) begin
                $display("%s passed, top of stack %h", test_name, top_of_stack);
                n_pass = n_pass + 1;
            end else begin
                n_fail = n_fail + 1;
            end
            tests_checked = tests_checked + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the processor never halted");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1fcb_eb12));
        rst_req   = 1'b1;
        prog_we   = 1'b0;
        prog_addr = 8'd0;
        prog_data = 8'd0;
        prog_len  = 0;
        for (int i = 0; i < 256; i++) begin
            prog[8'(i)] = 8'd0;
        end
        for (int i = 0; i < 729; i++) begin
            model_mem[10'(i)] = 0;
        end

        prog_len = 0;
        emit_push(127);
        emit_push(-128);
        emit(OP_ADD);
        emit_push(100);
        emit(OP_SUB);
        emit(OP_HALT);
        run_test("arith_basic");

        prog_len = 0;
        emit_push(127);
        for (int i = 0; i < 7; i++) begin
            emit(OP_DUP);
            emit(OP_ADD);
        end
        emit(OP_HALT);
        run_test("arith_wrap");

        prog_len = 0;
        emit_push(-128);
        for (int i = 0; i < 6; i++) begin
            emit(OP_DUP);
            emit(OP_ADD);
        end
        emit_push(127);
        for (int i = 0; i < 4; i++) begin
            emit(OP_DUP);
            emit(OP_ADD);
        end
        emit(OP_SUB);
        emit(OP_HALT);
        run_test("sub_wrap");

        prog_len = 0;
        emit_push(121);
        emit(OP_NEG);
        emit(OP_HALT);
        run_test("logic_neg");

        prog_len = 0;
        emit_push(100);
        emit_push(-77);
        emit(OP_CONS);
        emit(OP_HALT);
        run_test("logic_cons");

        prog_len = 0;
        emit_push(55);
        emit_push(-13);
        emit(OP_ANY);
        emit(OP_NEG);
        emit(OP_HALT);
        run_test("logic_any");

        prog_len = 0;
        emit_push(40);
        emit_push(-9);
        emit(OP_SWAP);
        emit(OP_DUP);
        emit(OP_ADD);
        emit(OP_SUB);
        emit(OP_HALT);
        run_test("stack_swap_dup");

        prog_len = 0;
        emit_push(5);
        emit_push(6);
        emit(OP_DUP);
        emit(OP_DROP);
        emit(OP_DROP);
        emit(OP_HALT);
        run_test("stack_drop");

        // Address -121 is five minus trits and the highest reachable cell
        prog_len = 0;
        emit_push(-121);
        emit_push(77);
        emit(OP_STORE);
        emit_push(13);
        emit_push(-50);
        emit(OP_STORE);
        emit_push(-121);
        emit(OP_LOAD);
        emit_push(13);
        emit(OP_LOAD);
        emit(OP_SUB);
        emit(OP_HALT);
        run_test("mem_store_load");

        prog_len = 0;
        emit_push(40);
        emit(OP_LOAD);
        emit_push(9);
        emit(OP_ADD);
        emit(OP_HALT);
        run_test("mem_unwritten");

        // Count 5 down to 0 leaving each value stacked, then add them up
        prog_len = 0;
        emit_push(5);
        emit(OP_DUP);
        emit_push(-1);
        emit(OP_ADD);
        emit(OP_DUP);
        emit(OP_BRZ);
        emit(11);
        emit(OP_JMP);
        emit(2);
        for (int i = 0; i < 5; i++) begin
            emit(OP_ADD);
        end
        emit(OP_HALT);
        run_test("loop_countdown");

        prog_len = 0;
        emit_push(7);
        emit(OP_JMP);
        emit(6);
        emit_push(99);
        emit(OP_HALT);
        run_test("jmp_skip");

        prog_len = 0;
        emit_push(3);
        emit(2);
        emit(40);
        emit(200);
        emit_push(4);
        emit(OP_ADD);
        emit(OP_HALT);
        run_test("nop_opcode");

        // Fill all sixteen slots and drain them so the slot under an empty stack is nonzero
        prog_len = 0;
        for (int i = 0; i < STACK_DEPTH; i++) begin
            emit_push(i + 1);
        end
        for (int i = 0; i < STACK_DEPTH; i++) begin
            emit(OP_DROP);
        end
        emit(OP_HALT);
        run_test("halt_empty");

        for (int t = 0; t < RANDOM_TESTS; t++) begin
            build_random_program();
            run_test($sformatf("random_%0d", t));
        end

        $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && n_pass == FIXED_TESTS + RANDOM_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/ternary_cpu_assert.sv ====
`timescale 1ns/1ps

module ternary_cpu_assert #(
    parameter  int STACK_DEPTH = 16,
    localparam int DEPTH_W     = $clog2(STACK_DEPTH + 1)
) (
    input logic               clk,
    input logic               rst,
    input isa_pkg::stack_op_e stack_op,
    input logic [DEPTH_W-1:0] depth,
    input logic               halted
);
    // Single-entry pops
    pop_one_a: assert property (@(posedge clk) disable iff (rst)
        (stack_op == isa_pkg::ST_POP || stack_op == isa_pkg::ST_POP_SET) |->
            depth >= DEPTH_W'(1))
        else $error("Stack underflow on a single pop");

    // STORE drops address and data together
    pop_two_a: assert property (@(posedge clk) disable iff (rst)
        (stack_op == isa_pkg::ST_POP2) |-> depth >= DEPTH_W'(2))
        else $error("Stack underflow on a double pop");

    push_room_a: assert property (@(posedge clk) disable iff (rst)
        (stack_op == isa_pkg::ST_PUSH) |-> depth < DEPTH_W'(STACK_DEPTH))
        else $error("Stack overflow on push");

    halt_sticky_a: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)
        else $error("Halted flag dropped without reset");

endmodule
